/* list.f */
source/fdc_pkg.sv
source/fdc_host_port.sv
source/fdc_cmd_decode.sv
source/fdc_seek_drive.sv
source/fdc_result.sv
source/fdc_top.sv
bench/tb_fdc.sv

/* Makefile */
SOURCES := $(wildcard source/*.sv bench/*.sv)

all: run

obj_dir/Vtb_fdc: $(SOURCES) list.f
	verilator --binary --timing --assert -f list.f --top-module tb_fdc -o Vtb_fdc

run: obj_dir/Vtb_fdc
	./obj_dir/Vtb_fdc | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" sim.log || { echo "simulation ended without result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* bench/tb_fdc.sv */
// ======================================================================
// testbench for the floppy controller command engine. drives the host
// bus with random commands from a fixed seed and checks every result
// byte and status read against a small model of the controller
// ======================================================================
`timescale 1ns/100ps

module tb_fdc
	import fdc_pkg::*;
();

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       ce, a0, rd_n, wr_n, fast;
	logic [7:0] din, dout;
	logic [1:0] ready, motor, available, wp;

	// model state
	logic [7:0] m_pcn [2];
	logic       m_int [2];
	logic       m_ok  [2];
	logic [3:0] m_rate;

	integer seed, errors, checks, err_mark, tests_run, tests_failed;

	fdc_top dut_i (
		.clk_sys(clk_sys), .reset(reset), .i_ce(ce), .i_a0(a0), .i_rd_n(rd_n),
		.i_wr_n(wr_n), .i_din(din), .o_dout(dout), .i_ready(ready), .i_motor(motor),
		.i_available(available), .i_wp(wp), .i_fast(fast)
	);

	always #5 clk_sys = ~clk_sys;

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		rand_below = int'(r % n);
	endfunction

	// ==================================================================
	// bus access, all entered 1 ns after a rising edge
	// ==================================================================
	task automatic bus_write(input logic addr, input logic [7:0] value);
		a0   = addr;
		din  = value;
		wr_n = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1 wr_n = 1'b1;
		@(posedge clk_sys); // one idle cycle between accesses
		#1;
	endtask

	task automatic bus_read(input logic addr, output logic [7:0] value);
		a0   = addr;
		rd_n = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1 value = dout;    // sampled at the end of the strobe
		rd_n = 1'b1;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("Error at %0t ns: %s expected 0x%02h, got 0x%02h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	// polls the main status register until the masked bits match
	task automatic wait_msr(input logic [7:0] mask, input logic [7:0] value,
		input integer max_polls, input string what);
		logic [7:0] msr;
		integer     polls;
		polls = 0;
		bus_read(1'b0, msr);
		while ((msr & mask) != value && polls < max_polls) begin
			polls++;
			bus_read(1'b0, msr);
		end
		assert ((msr & mask) == value) else begin
			$display("Timeout at %0t ns while waiting for %s", $time, what);
			errors++;
		end
	endtask

	// ==================================================================
	// commands with model updates
	// ==================================================================
	task automatic sense_int_check();
		logic [7:0] got, st0;
		logic       sel;
		bus_write(1'b1, 8'h08);
		wait_msr(8'hc0, 8'hc0, 50, "result phase of SENSE INTERRUPT");
		bus_read(1'b1, got);
		if (m_int[0] || m_int[1]) begin
			sel    = !m_int[0];                     // drive 0 wins
			st0    = (m_ok[sel] && ready[sel]) ? 8'h20 : 8'he8;
			st0[0] = sel;
			check_byte("o_dout ST0", st0, got);
			bus_read(1'b1, got);
			check_byte("o_dout PCN", m_pcn[sel], got);
			m_int[sel] = 1'b0;
		end else begin
			check_byte("o_dout ST0", 8'h80, got);
		end
		wait_msr(8'h10, 8'h00, 50, "CB to clear after SENSE INTERRUPT");
	endtask

	task automatic seek_cmd(input logic drv, input logic [7:0] cyl);
		logic err;
		bus_write(1'b1, 8'h0f);
		bus_write(1'b1, {7'd0, drv});
		bus_write(1'b1, cyl);
		err        = !((motor[drv] && ready[drv] && cyl < max_tracks) || cyl == 8'h00);
		m_int[drv] = 1'b1;
		m_ok[drv]  = !err;
		if (!err)
			m_pcn[drv] = cyl;
		wait_msr(8'h13, 8'h00, 100, "end of seek");
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %0d %-24s ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %-24s %0d errors", tests_run, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	initial begin
		logic [7:0] got, cyl, op, st3, dmask;
		logic       d;
		integer     limit;
		seed = 32'h5218;
		errors       = 0;
		checks       = 0;
		err_mark     = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset     = 1'b1;
		ce        = 1'b1;
		a0        = 1'b0;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		din       = 8'h00;
		ready     = 2'b11;
		motor     = 2'b11;
		available = 2'b11;
		wp        = 2'b00;
		fast      = 1'b1;
		for (int i = 0; i < 2; i++) begin
			m_pcn[i] = 8'h00;
			m_int[i] = 1'b0;
			m_ok[i]  = 1'b0;
		end
		m_rate = 4'd4;
		repeat (5) @(posedge clk_sys);
		#1 reset = 1'b0;

		// status and empty sense interrupt after reset
		bus_read(1'b0, got);
		check_byte("o_dout MSR", 8'h80, got);
		sense_int_check();
		finish_test("reset state");

		for (int i = 0; i < 8; i++) begin
			d = rand_below(2) != 0;
			seek_cmd(d, 8'(rand_below(int'(max_tracks))));
			sense_int_check();
		end
		finish_test("fast seeks");

		// either not ready or a cylinder off the media
		for (int i = 0; i < 6; i++) begin
			d = rand_below(2) != 0;
			if (rand_below(2) != 0) begin
				ready[d] = 1'b0;
				cyl      = 8'(1 + rand_below(255));
			end else begin
				cyl = 8'(int'(max_tracks) + rand_below(256 - int'(max_tracks)));
			end
			seek_cmd(d, cyl);
			sense_int_check();
			ready = 2'b11;
		end
		finish_test("seek errors");

		bus_write(1'b1, 8'h03);
		bus_write(1'b1, {4'hf, 4'(rand_below(16))});
		bus_write(1'b1, 8'(rand_below(256)));
		m_rate = 4'hf;
		m_int[0] = 1'b0;
		m_int[1] = 1'b0;
		d   = rand_below(2) != 0;
		cyl = 8'(1 + rand_below(4));
		seek_cmd(d, cyl);
		sense_int_check();
		fast = 1'b0;
		dmask = 8'h01 << d;
		bus_write(1'b1, 8'h07);
		bus_write(1'b1, {7'd0, d});
		wait_msr(dmask, dmask, 100, "drive busy to rise on RECALIBRATE");
		limit = (2 * (16 - int'(m_rate)) * (int'(cycles_per_ms) + 1) * (int'(cyl) + 1)
			+ 100) / 5;
		wait_msr(dmask, 8'h00, limit, "drive busy to fall on RECALIBRATE");
		m_pcn[d] = 8'h00;
		m_int[d] = 1'b1;
		m_ok[d]  = 1'b1;
		sense_int_check();
		fast = 1'b1;
		finish_test("specify and recalibrate");

		for (int i = 0; i < 6; i++) begin
			ready     = 2'(rand_below(4));
			available = 2'(rand_below(4));
			wp        = 2'(rand_below(4));
			d         = rand_below(2) != 0;
			bus_write(1'b1, 8'h04);
			bus_write(1'b1, {7'd0, d});
			m_int[0] = 1'b0;
			m_int[1] = 1'b0;
			st3    = 8'h00;
			st3[6] = ready[d] & wp[d];                 // write protected
			st3[5] = available[d];
			st3[4] = ready[d] & (m_pcn[d] == 8'h00);   // track 0
			st3[0] = d;
			wait_msr(8'hc0, 8'hc0, 50, "result phase of SENSE DRIVE");
			bus_read(1'b1, got);
			check_byte("o_dout ST3", st3, got);
			wait_msr(8'h10, 8'h00, 50, "CB to clear after SENSE DRIVE");
		end
		ready     = 2'b11;
		available = 2'b11;
		wp        = 2'b00;
		for (int i = 0; i < 4; i++) begin
			op = 8'(rand_below(256));
			while (op == 8'h03 || op == 8'h04 || op == 8'h07 || op == 8'h08 || op == 8'h0f)
				op = 8'(rand_below(256));
			bus_write(1'b1, op);
			wait_msr(8'hc0, 8'hc0, 50, "result phase of an invalid opcode");
			bus_read(1'b1, got);
			check_byte("o_dout ST0", 8'h80, got);
			wait_msr(8'h10, 8'h00, 50, "CB to clear after an invalid opcode");
			bus_read(1'b0, got);
			check_byte("o_dout MSR", 8'h80, got);
		end
		finish_test("sense drive and invalid");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* source/fdc_top.sv */
// ======================================================================
// floppy controller command engine, top level. connects the bus port,
// the command decoder, one seek engine per drive and the result phase
// ======================================================================
`timescale 1ns/100ps

module fdc_top
	import fdc_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       i_ce,
	input  logic       i_a0,
	input  logic       i_rd_n,
	input  logic       i_wr_n,
	input  logic [7:0] i_din,
	output logic [7:0] o_dout,
	input  logic [1:0] i_ready,     // disk present per drive
	input  logic [1:0] i_motor,
	input  logic [1:0] i_available, // reported in ST3 only
	input  logic [1:0] i_wp,
	input  logic       i_fast       // immediate seeks
);

	host_req_t   host;
	seek_req_t   seek0, seek1;
	drive_stat_t stat0, stat1;
	result_req_t result;
	logic [3:0]  step_rate;
	logic        busy, dio;
	logic [7:0]  data_reg;
	logic        result_active, result_done;
	logic [1:0]  clear_int;
	logic        seek_ok0, seek_ok1;

	fdc_host_port host_port_i (
		.clk_sys(clk_sys), .reset(reset), .i_ce(i_ce), .i_a0(i_a0),
		.i_rd_n(i_rd_n), .i_wr_n(i_wr_n), .i_din(i_din),
		.i_busy(busy), .i_dio(dio), .i_seeking({stat1.seeking, stat0.seeking}),
		.i_data_reg(data_reg), .o_host(host), .o_dout(o_dout)
	);

	fdc_cmd_decode cmd_decode_i (
		.clk_sys(clk_sys), .reset(reset), .i_host(host), .i_ready(i_ready),
		.i_motor(i_motor), .i_result_done(result_done), .i_result_active(result_active),
		.i_clear_int(clear_int), .o_seek0(seek0), .o_seek1(seek1), .o_result(result),
		.o_step_rate(step_rate), .o_busy(busy), .o_dio(dio)
	);

	fdc_seek_drive seek_drive0_i (
		.clk_sys(clk_sys), .reset(reset), .i_ce(i_ce), .i_fast(i_fast),
		.i_step_rate(step_rate), .i_req(seek0), .o_stat(stat0), .o_seek_ok(seek_ok0)
	);

	fdc_seek_drive seek_drive1_i (
		.clk_sys(clk_sys), .reset(reset), .i_ce(i_ce), .i_fast(i_fast),
		.i_step_rate(step_rate), .i_req(seek1), .o_stat(stat1), .o_seek_ok(seek_ok1)
	);

	fdc_result result_i (
		.clk_sys(clk_sys), .reset(reset), .i_host(host), .i_req(result),
		.i_stat0(stat0), .i_stat1(stat1), .i_seek_ok({seek_ok1, seek_ok0}),
		.i_ready(i_ready), .i_available(i_available), .i_wp(i_wp),
		.o_data_reg(data_reg), .o_active(result_active), .o_done(result_done),
		.o_clear_int(clear_int)
	);

endmodule

/* source/fdc_result.sv */
// ======================================================================
// result phase. builds ST0/ST3 bytes from the drive state and hands
// them out one per data register read, then releases the decoder
// ======================================================================
`timescale 1ns/100ps

module fdc_result
	import fdc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  host_req_t   i_host,
	input  result_req_t i_req,
	input  drive_stat_t i_stat0,
	input  drive_stat_t i_stat1,
	input  logic [1:0]  i_seek_ok,
	input  logic [1:0]  i_ready,
	input  logic [1:0]  i_available,
	input  logic [1:0]  i_wp,
	output logic [7:0]  o_data_reg,
	output logic        o_active,
	output logic        o_done,
	output logic [1:0]  o_clear_int
);

	typedef enum logic [1:0] {rs_idle, rs_first, rs_second} rstate_e;

	rstate_e           state;
	cmd_e              kind;
	logic              drive;    // drive named by sense drive
	logic              sel;      // drive reported by sense int
	drive_stat_t [1:0] stat;
	logic              int_sel;
	logic [7:0]        st0, st3;

	assign stat    = {i_stat1, i_stat0};
	assign int_sel = ~stat[0].int_pending; // drive 0 first

	assign st0 = ((i_seek_ok[int_sel] & i_ready[int_sel]) ? st0_seek_end : st0_seek_fail)
		| {7'd0, int_sel};
	assign st3 = {1'b0, i_ready[drive] & i_wp[drive], i_available[drive],
		i_ready[drive] & (stat[drive].pcn == 8'h00), 3'b000, drive};

	always_ff @(posedge clk_sys) begin
		o_done      <= 1'b0;
		o_clear_int <= 2'b00;
		if (reset) begin
			state <= rs_idle;
			kind  <= cmd_none;
			drive <= 1'b0;
			sel   <= 1'b0;
		end else begin
			case (state)
				rs_idle: if (i_req.start) begin
					kind  <= i_req.kind;
					drive <= i_req.arg[0];
					state <= rs_first;
				end
				rs_first: if (i_host.rd_stb) begin
					if (kind == cmd_sense_int && (stat[0].int_pending || stat[1].int_pending)) begin
						o_data_reg <= st0;
						sel        <= int_sel;
						state      <= rs_second;
					end else begin
						o_data_reg <= (kind == cmd_sense_drive) ? st3 : st0_invalid;
						o_done     <= 1'b1;
						state      <= rs_idle;
					end
				end
				rs_second: if (i_host.rd_stb) begin
					o_data_reg       <= stat[sel].pcn;
					o_clear_int[sel] <= 1'b1;  // interrupt reported, drop it
					o_done           <= 1'b1;
					state            <= rs_idle;
				end
				default: state <= rs_idle;
			endcase
		end
	end

	assign o_active = state != rs_idle;

endmodule

/* source/fdc_seek_drive.sv */
// ======================================================================
// head stepping engine for one drive. moves pcn one cylinder per step
// toward ncn, or at once in fast mode, and raises the pending interrupt
// at the end of the seek. step progress runs on the clock enable
// ======================================================================
`timescale 1ns/100ps

module fdc_seek_drive
	import fdc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        i_ce,
	input  logic        i_fast,
	input  logic [3:0]  i_step_rate,
	input  seek_req_t   i_req,
	output drive_stat_t o_stat,
	output logic        o_seek_ok
);

	typedef enum logic [1:0] {sk_idle, sk_move, sk_wait} seek_e;

	seek_e       state;
	logic [7:0]  ncn, pcn;
	logic        int_pending;
	logic        seek_ok;
	logic [3:0]  step_cnt;  // counts up to 15 from the step rate
	logic [19:0] ms_timer;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= sk_idle;
			ncn         <= 8'h00;
			pcn         <= 8'h00;
			int_pending <= 1'b0;
			seek_ok     <= 1'b0;
		end else begin
			if (i_ce) begin
				case (state)
					sk_move: begin
						if (pcn == ncn) begin
							int_pending <= 1'b1;
							seek_ok     <= 1'b1;
							state       <= sk_idle;
						end else if (i_fast) begin
							pcn <= ncn;
						end else begin
							pcn      <= (pcn > ncn) ? pcn - 8'd1 : pcn + 8'd1;
							step_cnt <= i_step_rate;
							ms_timer <= cycles_per_ms;
							state    <= sk_wait;
						end
					end
					sk_wait: begin
						if (ms_timer != 20'd0) begin
							ms_timer <= ms_timer - 20'd1;
						end else if (step_cnt != 4'hf) begin
							step_cnt <= step_cnt + 4'd1; // another ms of this step
							ms_timer <= cycles_per_ms;
						end else begin
							state <= sk_move;
						end
					end
					default: ;
				endcase
			end
			if (i_req.clear_int) int_pending <= 1'b0;
			if (i_req.start) begin
				ncn     <= i_req.ncn;
				seek_ok <= 1'b0;
				if (i_req.seek_err) begin
					int_pending <= 1'b1;   // head stays put
					state       <= sk_idle;
				end else begin
					int_pending <= 1'b0;
					state       <= sk_move;
				end
			end
		end
	end

	assign o_stat.seeking     = state != sk_idle;
	assign o_stat.int_pending = int_pending;
	assign o_stat.pcn         = pcn;
	assign o_seek_ok          = seek_ok;

	// decoder keeps illegal targets away from the engine
	a_pcn_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		pcn < max_tracks)
		else $error("pcn reached max_tracks");

endmodule

/* source/fdc_cmd_decode.sv */
// ======================================================================
// command phase FSM. decodes the opcode byte, collects parameter bytes,
// keeps the step rate and sends orders to the seek engines and to the
// result phase. the FSM waits in the result state until it is released
// ======================================================================
`timescale 1ns/100ps

module fdc_cmd_decode
	import fdc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  host_req_t   i_host,
	input  logic [1:0]  i_ready,
	input  logic [1:0]  i_motor,
	input  logic        i_result_done,
	input  logic        i_result_active,
	input  logic [1:0]  i_clear_int,     // sense int clears from result phase
	output seek_req_t   o_seek0,
	output seek_req_t   o_seek1,
	output result_req_t o_result,
	output logic [3:0]  o_step_rate,
	output logic        o_busy,
	output logic        o_dio
);

	typedef enum logic [1:0] {st_idle, st_param1, st_param2, st_result} state_e;

	state_e               state;
	cmd_e                 cmd, op;
	logic                 drive;
	logic [3:0]           step_rate;
	seek_req_t [1:0]      seek_q;
	result_req_t          res_q;

	function automatic cmd_e decode_op(input logic [7:0] opcode);
		casez (opcode)
			8'b000_00011: decode_op = cmd_specify;
			8'b000_00100: decode_op = cmd_sense_drive;
			8'b000_00111: decode_op = cmd_recalibrate;
			8'b000_01000: decode_op = cmd_sense_int;
			8'b000_01111: decode_op = cmd_seek;
			default:      decode_op = cmd_invalid;
		endcase
	endfunction

	assign op = decode_op(i_host.data);

	always_ff @(posedge clk_sys) begin
		seek_q[0].start     <= 1'b0;  // pulses
		seek_q[0].clear_int <= 1'b0;
		seek_q[1].start     <= 1'b0;
		seek_q[1].clear_int <= 1'b0;
		res_q.start         <= 1'b0;
		if (reset) begin
			state     <= st_idle;
			cmd       <= cmd_none;
			drive     <= 1'b0;
			step_rate <= step_rate_rst;
			seek_q    <= '0;
			res_q     <= '0;
		end else if (i_host.wr_stb || state == st_result) begin
			case (state)
				st_idle: begin
					cmd <= op;
					if (op == cmd_sense_int || op == cmd_invalid) begin
						res_q <= '{start: 1'b1, kind: op, arg: 8'h00};
						state <= st_result;
					end else begin
						if (op == cmd_specify || op == cmd_sense_drive) begin
							seek_q[0].clear_int <= 1'b1;
							seek_q[1].clear_int <= 1'b1;
						end
						state <= st_param1;
					end
				end
				st_param1: begin
					drive <= i_host.data[0];
					case (cmd)
						cmd_specify: begin
							step_rate <= i_host.data[7:4]; // SRT nibble, HUT ignored
							state     <= st_param2;
						end
						cmd_sense_drive: begin
							res_q <= '{start: 1'b1, kind: cmd_sense_drive, arg: i_host.data};
							state <= st_result;
						end
						cmd_recalibrate: begin
							seek_q[i_host.data[0]] <= '{start: 1'b1, clear_int: 1'b1,
								ncn: 8'h00, seek_err: 1'b0};
							state <= st_idle;
						end
						default: begin   // seek, wait for NCN
							seek_q[i_host.data[0]].clear_int <= 1'b1;
							state <= st_param2;
						end
					endcase
				end
				st_param2: begin
					if (cmd == cmd_seek) begin
						seek_q[drive].start    <= 1'b1;
						seek_q[drive].ncn      <= i_host.data;
						seek_q[drive].seek_err <= !((i_motor[drive] && i_ready[drive] &&
							i_host.data < max_tracks) || i_host.data == 8'h00);
					end
					state <= st_idle;   // specify drops the HLT byte
				end
				default: if (i_result_done) state <= st_idle;
			endcase
		end
	end

	always_comb begin
		o_seek0           = seek_q[0];
		o_seek0.clear_int = seek_q[0].clear_int | i_clear_int[0];
		o_seek1           = seek_q[1];
		o_seek1.clear_int = seek_q[1].clear_int | i_clear_int[1];
	end

	assign o_result    = res_q;
	assign o_step_rate = step_rate;
	assign o_busy      = state != st_idle;
	assign o_dio       = state == st_result;

	// new orders only go out while the result phase is quiet
	a_start_result_idle: assert property (@(posedge clk_sys) disable iff (reset)
		(o_result.start || o_seek0.start || o_seek1.start) |-> !i_result_active)
		else $error("command issued while result phase active");

endmodule

/* source/fdc_host_port.sv */
// ======================================================================
// host bus port. turns data register strobes into one-cycle events,
// keeps the main status register and muxes the byte read by the host
// ======================================================================
`timescale 1ns/100ps

module fdc_host_port
	import fdc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        i_ce,
	input  logic        i_a0,
	input  logic        i_rd_n,
	input  logic        i_wr_n,
	input  logic [7:0]  i_din,
	input  logic        i_busy,     // CB
	input  logic        i_dio,
	input  logic [1:0]  i_seeking,
	input  logic [7:0]  i_data_reg,
	output host_req_t   o_host,
	output logic [7:0]  o_dout
);

	logic       rd, wr;
	logic       old_rd, old_wr;
	logic [7:0] msr, msr_next;

	assign wr = ~i_wr_n & i_rd_n;
	assign rd = i_wr_n & ~i_rd_n;

	always_comb begin
		msr_next          = 8'h00;
		msr_next[msr_d0b] = i_seeking[0];
		msr_next[msr_d1b] = i_seeking[1];
		msr_next[msr_cb]  = i_busy;
		msr_next[msr_dio] = i_dio;
		msr_next[msr_rqm] = 1'b1;    // no execution phase, always ready
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_rd <= 1'b0;
			old_wr <= 1'b0;
			msr    <= 8'h80;
		end else if (i_ce) begin
			old_rd <= rd;
			old_wr <= wr;
			msr    <= msr_next;
		end
	end

	// first enabled cycle of an access to the data register
	assign o_host.wr_stb = i_ce & i_a0 & wr & ~old_wr;
	assign o_host.rd_stb = i_ce & i_a0 & rd & ~old_rd;
	assign o_host.data   = i_din;

	assign o_dout = i_a0 ? i_data_reg : msr;

	// both strobes low at once is neither access and would be dropped
	a_no_rd_wr_overlap: assert property (@(posedge clk_sys) disable iff (reset)
		i_ce |-> (i_rd_n || i_wr_n))
		else $error("read and write strobe low in the same cycle");

endmodule

/* source/fdc_pkg.sv */
// ======================================================================
// shared constants, status bit positions, opcodes and bus structs
// for the floppy controller command engine. every RTL file imports
// this package in its module header
// ======================================================================

package fdc_pkg;

	localparam logic [19:0] cycles_per_ms = 20'd4000; // clock-enable cycles per ms of step time
	localparam logic [7:0]  max_tracks    = 8'd40;    // cylinders on the emulated media
	localparam logic [3:0]  step_rate_rst = 4'd4;     // SPECIFY step rate after reset

	// main status register bit positions
	localparam int unsigned msr_d0b = 0;
	localparam int unsigned msr_d1b = 1;
	localparam int unsigned msr_cb  = 4;
	localparam int unsigned msr_dio = 6;
	localparam int unsigned msr_rqm = 7;

	// ST0 values returned in the result phase
	localparam logic [7:0] st0_invalid   = 8'h80; // invalid command or no interrupt
	localparam logic [7:0] st0_seek_end  = 8'h20; // seek end, normal termination
	localparam logic [7:0] st0_seek_fail = 8'he8; // seek end, abnormal, not ready

	typedef enum logic [2:0] {
		cmd_none,
		cmd_specify,
		cmd_sense_int,
		cmd_sense_drive,
		cmd_seek,
		cmd_recalibrate,
		cmd_invalid
	} cmd_e;

	typedef struct packed {
		logic       wr_stb; // rising data register write
		logic       rd_stb; // rising data register read
		logic [7:0] data;
	} host_req_t;

	typedef struct packed {
		logic       start;
		logic       clear_int;
		logic [7:0] ncn;      // target cylinder
		logic       seek_err;
	} seek_req_t;

	typedef struct packed {
		logic       seeking;
		logic       int_pending;
		logic [7:0] pcn;         // present cylinder
	} drive_stat_t;

	typedef struct packed {
		logic       start;
		cmd_e       kind;
		logic [7:0] arg;   // drive byte for sense drive
	} result_req_t;

endpackage
